// File: Bender.yml
package:
  name: conv_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/conv_pkg.sv
      - source/line_memory.sv
      - source/mem_arbiter.sv
      - source/row_loader.sv
      - source/mac_stage.sv
      - source/conv_engine.sv
      - source/conv_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/conv_checker.sv
      - testbench/conv_tb.sv

// File: all.f
+incdir+source
source/conv_pkg.sv
source/line_memory.sv
source/mem_arbiter.sv
source/row_loader.sv
source/mac_stage.sv
source/conv_engine.sv
source/conv_top.sv
testbench/conv_checker.sv
testbench/conv_tb.sv

// File: source/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// row geometry
`define CONV_PIXELS 32
`define CONV_RESULTS 30

// line memory, two banks of one row each
`define CONV_BANKS 2
`define CONV_ADDR_W 6 // bank bit + pixel position

// fixed kernel
`define CONV_TAP0 (-8'sd1)
`define CONV_TAP1 (8'sd2)
`define CONV_TAP2 (-8'sd1)

`endif

// File: source/conv_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module conv_engine (
	input logic clk,
	input logic rst,
	input logic row_avail,
	input logic row_bank,
	output logic row_taken,
	output logic rd_req,
	output conv_pkg::addr_t rd_addr,
	input logic rd_gnt,
	input conv_pkg::pixel_t mem_rdata,
	output logic result_valid,
	output conv_pkg::index_t result_index,
	output conv_pkg::acc_t result_value,
	output logic row_done
);
	import conv_pkg::*;

	engine_state_t state;
	logic bank;
	logic [`CONV_ADDR_W-2:0] rd_ptr;
	logic pix_valid; // mem_rdata holds a granted pixel
	logic [`CONV_ADDR_W-2:0] pix_cnt;
	logic first_out;
	acc_t sum0;
	acc_t sum1;
	acc_t sum2;

	assign rd_req = (state == EN_READ);
	assign rd_addr = {bank, rd_ptr};

	// window complete from the third pixel on
	assign first_out = (pix_cnt >= (`CONV_PIXELS - `CONV_RESULTS));

	// transposed chain, every stage sees the same pixel
	mac_stage u_stage0 (
		.clk(clk),
		.rst(rst),
		.en(pix_valid),
		.pixel(mem_rdata),
		.tap(`CONV_TAP0),
		.sum_in('0),
		.sum_out(sum0)
	);

	mac_stage u_stage1 (
		.clk(clk),
		.rst(rst),
		.en(pix_valid),
		.pixel(mem_rdata),
		.tap(`CONV_TAP1),
		.sum_in(sum0),
		.sum_out(sum1)
	);

	mac_stage u_stage2 (
		.clk(clk),
		.rst(rst),
		.en(pix_valid),
		.pixel(mem_rdata),
		.tap(`CONV_TAP2),
		.sum_in(sum1),
		.sum_out(sum2)
	);

	assign result_value = sum2;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= EN_IDLE;
			bank <= 1'b0;
			rd_ptr <= '0;
			pix_valid <= 1'b0;
			pix_cnt <= '0;
			result_valid <= 1'b0;
			result_index <= '0;
			row_taken <= 1'b0;
			row_done <= 1'b0;
		end else begin
			row_taken <= 1'b0;
			pix_valid <= rd_req && rd_gnt;
			if (rd_req && rd_gnt) begin
				pix_cnt <= rd_ptr;
			end
			result_valid <= pix_valid && first_out;
			if (pix_valid && first_out) begin
				result_index <= index_t'(pix_cnt - (`CONV_PIXELS - `CONV_RESULTS));
			end
			row_done <= result_valid && (result_index == `CONV_RESULTS-1);
			case (state)
				EN_IDLE: begin
					if (row_avail) begin
						bank <= row_bank;
						rd_ptr <= '0;
						state <= EN_READ;
					end
				end
				EN_READ: begin
					if (rd_gnt) begin
						if (rd_ptr == `CONV_PIXELS-1) begin
							row_taken <= 1'b1; // bank can be refilled
							state <= EN_DRAIN;
						end else begin
							rd_ptr <= rd_ptr + 1'b1;
						end
					end
				end
				EN_DRAIN: begin
					if (pix_valid && (pix_cnt == `CONV_PIXELS-1)) begin
						state <= EN_DONE;
					end
				end
				EN_DONE: state <= EN_IDLE; // last result out this cycle
				default: state <= EN_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/conv_pkg.sv
`default_nettype none

`include "conv_defines.svh"

package conv_pkg;

	typedef logic signed [7:0] pixel_t;
	typedef logic signed [17:0] acc_t;
	typedef logic [`CONV_ADDR_W-1:0] addr_t; // msb selects the bank
	typedef logic [4:0] index_t;
	typedef logic [`CONV_PIXELS*8-1:0] row_t; // pixel k at bits 8k+7:8k

	typedef enum logic {
		LD_IDLE,
		LD_WRITE
	} loader_state_t;

	typedef enum logic [1:0] {
		EN_IDLE,
		EN_READ,
		EN_DRAIN,
		EN_DONE
	} engine_state_t;

endpackage

`default_nettype wire

// File: source/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top (
	input logic clk,
	input logic rst,
	input logic row_valid,
	input conv_pkg::row_t row_data,
	output logic row_ready,
	output logic result_valid,
	output conv_pkg::index_t result_index,
	output conv_pkg::acc_t result_value,
	output logic row_done
);
	import conv_pkg::*;

	logic ld_req;
	logic ld_gnt;
	addr_t ld_addr;
	pixel_t ld_wdata;
	logic rd_req;
	logic rd_gnt;
	addr_t rd_addr;
	addr_t mem_addr;
	logic mem_we;
	pixel_t mem_wdata;
	pixel_t mem_rdata;
	logic row_avail;
	logic row_bank;
	logic row_taken;

	row_loader u_loader (
		.clk(clk),
		.rst(rst),
		.row_valid(row_valid),
		.row_data(row_data),
		.row_ready(row_ready),
		.ld_req(ld_req),
		.ld_addr(ld_addr),
		.ld_wdata(ld_wdata),
		.ld_gnt(ld_gnt),
		.row_avail(row_avail),
		.row_bank(row_bank),
		.row_taken(row_taken)
	);

	conv_engine u_engine (
		.clk(clk),
		.rst(rst),
		.row_avail(row_avail),
		.row_bank(row_bank),
		.row_taken(row_taken),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_gnt(rd_gnt),
		.mem_rdata(mem_rdata),
		.result_valid(result_valid),
		.result_index(result_index),
		.result_value(result_value),
		.row_done(row_done)
	);

	mem_arbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.ld_req(ld_req),
		.ld_addr(ld_addr),
		.ld_wdata(ld_wdata),
		.ld_gnt(ld_gnt),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_gnt(rd_gnt),
		.mem_addr(mem_addr),
		.mem_we(mem_we),
		.mem_wdata(mem_wdata)
	);

	line_memory u_memory (
		.clk(clk),
		.addr(mem_addr),
		.we(mem_we),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// File: source/line_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module line_memory (
	input logic clk,
	input conv_pkg::addr_t addr,
	input logic we,
	input conv_pkg::pixel_t wdata,
	output conv_pkg::pixel_t rdata
);
	import conv_pkg::*;

	pixel_t mem [0:`CONV_BANKS*`CONV_PIXELS-1];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// read data lags the address by one cycle
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// File: source/mac_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mac_stage (
	input logic clk,
	input logic rst,
	input logic en,
	input conv_pkg::pixel_t pixel,
	input conv_pkg::pixel_t tap,
	input conv_pkg::acc_t sum_in,
	output conv_pkg::acc_t sum_out
);
	import conv_pkg::*;

	acc_t product;

	// both operands sign extended before the multiply
	assign product = acc_t'(pixel) * acc_t'(tap);

	always_ff @(posedge clk) begin
		if (rst) begin
			sum_out <= '0;
		end else if (en) begin
			sum_out <= sum_in + product;
		end
	end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input logic clk,
	input logic rst,
	input logic ld_req,
	input conv_pkg::addr_t ld_addr,
	input conv_pkg::pixel_t ld_wdata,
	output logic ld_gnt,
	input logic rd_req,
	input conv_pkg::addr_t rd_addr,
	output logic rd_gnt,
	output conv_pkg::addr_t mem_addr,
	output logic mem_we,
	output conv_pkg::pixel_t mem_wdata
);
	logic last_ld; // loader held the most recent grant

	// on contention the peer that lost last time wins
	assign ld_gnt = ld_req && (!rd_req || !last_ld);
	assign rd_gnt = rd_req && !ld_gnt;

	assign mem_addr = ld_gnt ? ld_addr : rd_addr;
	assign mem_we = ld_gnt; // only the loader writes
	assign mem_wdata = ld_wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			last_ld <= 1'b0;
		end else begin
			if (ld_gnt) begin
				last_ld <= 1'b1;
			end else if (rd_gnt) begin
				last_ld <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/row_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module row_loader (
	input logic clk,
	input logic rst,
	input logic row_valid,
	input conv_pkg::row_t row_data,
	output logic row_ready,
	output logic ld_req,
	output conv_pkg::addr_t ld_addr,
	output conv_pkg::pixel_t ld_wdata,
	input logic ld_gnt,
	output logic row_avail,
	output logic row_bank,
	input logic row_taken
);
	import conv_pkg::*;

	loader_state_t state;
	row_t row_buf;
	logic [`CONV_ADDR_W-2:0] ptr; // pixel being written
	logic wr_bank;
	logic rd_bank; // next bank for the engine
	logic [`CONV_BANKS-1:0] full;
	logic accept;

	assign row_ready = (state == LD_IDLE) && !full[wr_bank];
	assign accept = row_valid && row_ready;

	assign ld_req = (state == LD_WRITE);
	assign ld_addr = {wr_bank, ptr};
	assign ld_wdata = row_buf[{ptr, 3'b000} +: 8];

	assign row_avail = full[rd_bank];
	assign row_bank = rd_bank;

	always_ff @(posedge clk) begin
		if (accept) begin
			row_buf <= row_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LD_IDLE;
			ptr <= '0;
			wr_bank <= 1'b0;
			rd_bank <= 1'b0;
			full <= '0;
		end else begin
			if (row_taken) begin
				full[rd_bank] <= 1'b0;
				rd_bank <= !rd_bank;
			end
			case (state)
				LD_IDLE: begin
					if (accept) begin
						ptr <= '0;
						state <= LD_WRITE;
					end
				end
				LD_WRITE: begin
					if (ld_gnt) begin
						if (ptr == `CONV_PIXELS-1) begin
							full[wr_bank] <= 1'b1; // row complete
							wr_bank <= !wr_bank;
							state <= LD_IDLE;
						end else begin
							ptr <= ptr + 1'b1;
						end
					end
				end
				default: state <= LD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: testbench/conv_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module conv_checker (
	input logic clk,
	input logic rst,
	input logic ld_req,
	input logic ld_gnt,
	input logic rd_req,
	input logic rd_gnt,
	input logic result_valid,
	input conv_pkg::index_t result_index,
	input logic row_done
);

	one_grant: assert property (@(posedge clk) disable iff (rst) !(ld_gnt && rd_gnt))
		else $error("loader and engine granted in the same cycle");

	ld_gnt_req: assert property (@(posedge clk) disable iff (rst) ld_gnt |-> ld_req)
		else $error("loader granted without a request");

	rd_gnt_req: assert property (@(posedge clk) disable iff (rst) rd_gnt |-> rd_req)
		else $error("engine granted without a request");

	index_range: assert property (@(posedge clk) disable iff (rst)
		result_index < `CONV_RESULTS)
		else $error("result index out of range");

	// first reset edge still sees power-up values
	quiet_in_reset: assert property (@(posedge clk)
		(rst && $past(rst)) |-> (!row_done && !result_valid))
		else $error("output strobe active during reset");

endmodule

`default_nettype wire

// File: testbench/conv_stim.txt
// each record: one row word, pixel 31 leftmost and pixel 0 rightmost,
// then 30 expected results as 18-bit two's complement, index 0 first
// mixed signs near both row ends
ce190000_00000000_00000000_00000000_00000000_00000000_00000000_64ff7f80
0017f 3ff1b 000c9 3ff9c 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000 3ffe7 00064
// all pixels 127
7f7f7f7f_7f7f7f7f_7f7f7f7f_7f7f7f7f_7f7f7f7f_7f7f7f7f_7f7f7f7f_7f7f7f7f
00000 00000 00000 00000 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000 00000 00000
// -128 at even pixels, 127 at odd pixels
7f807f80_7f807f80_7f807f80_7f807f80_7f807f80_7f807f80_7f807f80_7f807f80
001fe 3fe02 001fe 3fe02 001fe 3fe02 001fe 3fe02 001fe 3fe02
001fe 3fe02 001fe 3fe02 001fe 3fe02 001fe 3fe02 001fe 3fe02
001fe 3fe02 001fe 3fe02 001fe 3fe02 001fe 3fe02 001fe 3fe02
// single pixel 5 at position 10
00000000_00000000_00000000_00000000_00000000_00050000_00000000_00000000
00000 00000 00000 00000 00000 00000 00000 00000 3fffb 0000a
3fffb 00000 00000 00000 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000 00000 00000

// File: testbench/conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_defines.svh"

module conv_tb;
	import conv_pkg::*;

	localparam int RECORD = `CONV_RESULTS + 1; // row word then its results
	localparam int STIM_ROWS = 4;
	localparam int WAIT_LIMIT = 2000; // cycles

	logic clk;
	logic rst;
	logic row_valid;
	row_t row_data;
	logic row_ready;
	logic result_valid;
	index_t result_index;
	acc_t result_value;
	logic row_done;

	logic [255:0] stim [0:STIM_ROWS*RECORD-1];
	int row_expect [0:`CONV_RESULTS-1];
	int exp_value [$];
	int exp_index [$];
	string exp_test [$];
	string test_name;
	int errors;
	int timeouts;
	int rows_accepted;
	int done_count;
	int result_count;
	logic prev_final; // previous strobe was the last result of a row
	int r;

	conv_top u_dut (.*);

	bind conv_top conv_checker u_checker (.*);

	always #2 clk = !clk;

	task automatic check(input string test, input string what,
			input int expected, input int actual);
		if (expected !== actual) begin
			$display("error %s %s: expected %0d, actual %0d", test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic end_run();
		$display("results %0d, row_done %0d, errors %0d, timeouts %0d",
			result_count, done_count, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	endtask

	task automatic timeout_abort(input string what);
		$display("timeout in %s: %s", test_name, what);
		timeouts++;
		end_run();
	endtask

	function automatic logic drained();
		return exp_value.size() == 0 && done_count == rows_accepted;
	endfunction

	task automatic wait_ready();
		int waited;
		waited = 0;
		while (row_ready !== 1'b1 && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (row_ready !== 1'b1) begin
			timeout_abort("row_ready never went high");
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (!drained() && waited < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!drained()) begin
			timeout_abort("results or row_done still missing");
		end
	endtask

	// row_expect holds this row's results before the call
	task automatic send_row(input row_t data);
		int k;
		wait_ready();
		for (k = 0; k < `CONV_RESULTS; k++) begin
			exp_value.push_back(row_expect[k]);
			exp_index.push_back(k);
			exp_test.push_back(test_name);
		end
		rows_accepted++;
		row_valid = 1'b1;
		row_data = data;
		@(posedge clk);
		#1;
		row_valid = 1'b0;
	endtask

	task automatic send_file_row(input int rec);
		logic [17:0] raw;
		int k;
		for (k = 0; k < `CONV_RESULTS; k++) begin
			raw = stim[rec*RECORD + 1 + k][17:0];
			row_expect[k] = $signed(raw);
		end
		send_row(stim[rec*RECORD]);
	endtask

	task automatic send_random_row();
		row_t data;
		int k;
		for (k = 0; k < 8; k++) begin
			data[32*k +: 32] = $urandom();
		end
		for (k = 0; k < `CONV_RESULTS; k++) begin
			// taps -1, 2, -1 over pixels k to k+2
			row_expect[k] = 2 * $signed(data[8*k+8 +: 8]) - $signed(data[8*k +: 8])
				- $signed(data[8*k+16 +: 8]);
		end
		send_row(data);
	endtask

	// outputs are stable mid cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (result_valid) begin
				result_count++;
				if (exp_value.size() == 0) begin
					$display("result %0d arrived with no accepted row pending", result_index);
					errors++;
				end else begin
					check(exp_test[0], "index", exp_index.pop_front(), int'(result_index));
					check(exp_test.pop_front(), "value", exp_value.pop_front(),
						int'(result_value));
				end
			end
			if (row_done) begin
				done_count++;
				check("row_end", "row_done after result 29", 1, int'(prev_final));
			end
			prev_final = result_valid && (result_index == `CONV_RESULTS - 1);
		end
	end

	initial begin
		void'($urandom(32'h5a37_5dd7));
		clk = 1'b0;
		rst = 1'b1;
		row_valid = 1'b0;
		row_data = '0;
		errors = 0;
		timeouts = 0;
		rows_accepted = 0;
		done_count = 0;
		result_count = 0;
		prev_final = 1'b0;
		test_name = "reset";
		$readmemh("testbench/conv_stim.txt", stim);
		if ($isunknown(stim[STIM_ROWS*RECORD-1])) begin
			$display("stim file testbench/conv_stim.txt is missing or too short");
			errors++;
		end
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		test_name = "after_reset";
		check(test_name, "row_ready", 1, int'(row_ready));
		repeat (10) @(posedge clk); // no strobe may show up here
		#1;

		test_name = "single_row";
		send_file_row(0);
		wait_drain();

		test_name = "edge_rows"; // all 127, then alternating -128 and 127
		send_file_row(1);
		send_file_row(2);
		wait_drain();

		test_name = "back_to_back";
		for (r = 0; r < STIM_ROWS; r++) begin
			send_file_row(r);
		end
		wait_drain();

		test_name = "ignored_strobe";
		send_file_row(3);
		check(test_name, "row_ready while loading", 0, int'(row_ready));
		row_valid = 1'b1;
		row_data = {8{32'hdead_beef}};
		@(posedge clk);
		#1;
		row_valid = 1'b0;
		wait_drain();

		test_name = "random_rows";
		for (r = 0; r < 20; r++) begin
			repeat ($urandom_range(1, 12)) @(posedge clk);
			#1;
			send_random_row();
		end
		wait_drain();
		repeat (8) @(posedge clk);

		test_name = "summary";
		check(test_name, "row_done pulses", rows_accepted, done_count);
		check(test_name, "result strobes", rows_accepted * `CONV_RESULTS, result_count);
		end_run();
	end

endmodule

`default_nettype wire
